//--- dv/riscv_core_tb.sv
module riscv_core_tb;

  localparam int DATA_SIZE = 32;
  localparam int MEM_WORDS = 256;
  localparam int RESET_CYCLES = 16;
  localparam int DATA_WORD = 'h200 / 4;
  localparam logic [DATA_SIZE-1:0] STORE_ADDR = 32'h0000_0100;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  typedef struct {
    string                name;
    logic [31:0]          instr;
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
    logic [DATA_SIZE-1:0] expected;
    bit                   skip_slot;
    logic [4:0]           store_reg;
  } row_t;

  logic                 clock;
  logic                 reset;
  logic [DATA_SIZE-1:0] rd_data;
  logic [DATA_SIZE-1:0] mem_addr;
  logic [DATA_SIZE-1:0] wr_data;
  logic                 mem_wr_en;
  logic                 halted;

  logic [31:0]          mem [MEM_WORDS];
  logic [31:0]          image [MEM_WORDS];
  logic                 load_image;
  logic [DATA_SIZE-1:0] store_addr;
  logic [DATA_SIZE-1:0] store_data;
  int                   store_count;
  row_t                 rows [$];
  int                   seed = 70;
  int                   errors = 0;
  int                   failed_rows = 0;
  int                   cycles = 0;
  int                   cycle_limit;

  riscv_core #(
    .DATA_SIZE(DATA_SIZE)
  ) i_dut (
    .clock    (clock),
    .reset    (reset),
    .rd_data  (rd_data),
    .mem_addr (mem_addr),
    .wr_data  (wr_data),
    .mem_wr_en(mem_wr_en),
    .halted   (halted)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Combinational memory read
  assign rd_data = mem[mem_addr[9:2]];

  // Image copy happens during reset
  always @(posedge clock) begin
    if (load_image) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= image[i];
      end
      store_count <= 0;
    end else if (mem_wr_en) begin
      mem[mem_addr[9:2]] <= wr_data;
      store_addr <= mem_addr;
      store_data <= wr_data;
      store_count <= store_count + 1;
    end
  end

  // Every fetch and data access is word aligned
  always @(posedge clock) begin
    if (!reset && (mem_addr[1:0] != 2'b00)) begin
      $display("misaligned memory address %h at %0t", mem_addr, $time);
      errors++;
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the core never reached halt", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, riscv_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [11:0] imm);
    return enc_i(riscv_pkg::OP_IMM, f3, 5'd3, 5'd1, imm);
  endfunction

  function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], riscv_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [19:0] imm);
    return {imm, 5'd3, op};
  endfunction

  // Branch compares x1 with x2
  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] offset);
    riscv_pkg::instr_u w;
    w.b_fmt.imm_12   = offset[12];
    w.b_fmt.imm_10_5 = offset[10:5];
    w.b_fmt.rs2      = 5'd2;
    w.b_fmt.rs1      = 5'd1;
    w.b_fmt.funct3   = f3;
    w.b_fmt.imm_4_1  = offset[4:1];
    w.b_fmt.imm_11   = offset[11];
    w.b_fmt.opcode   = riscv_pkg::OP_BRANCH;
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] offset);
    riscv_pkg::instr_u w;
    w.j_fmt.imm_20    = offset[20];
    w.j_fmt.imm_10_1  = offset[10:1];
    w.j_fmt.imm_11    = offset[11];
    w.j_fmt.imm_19_12 = offset[19:12];
    w.j_fmt.rd        = 5'd3;
    w.j_fmt.opcode    = riscv_pkg::OP_JAL;
    return w;
  endfunction

  // RV32I result of an OP instruction
  function automatic logic [31:0] reference_op(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic add_row(input string name, input logic [31:0] instr,
                         input logic [DATA_SIZE-1:0] a, b, expected,
                         input bit skip_slot, input logic [4:0] store_reg);
    row_t row;
    row.name = name;
    row.instr = instr;
    row.a = a;
    row.b = b;
    row.expected = expected;
    row.skip_slot = skip_slot;
    row.store_reg = store_reg;
    rows.push_back(row);
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic        alt;
    add_row("add", enc_r(7'h00, 3'b000), 32'd5, 32'd7, 32'd12, 1'b0, 5'd3);
    add_row("sub", enc_r(7'h20, 3'b000), 32'd5, 32'd7, 32'hffff_fffe, 1'b0, 5'd3);
    add_row("and", enc_r(7'h00, 3'b111), 32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200, 1'b0, 5'd3);
    add_row("or", enc_r(7'h00, 3'b110), 32'hf0f0_0000, 32'h0f00_00ff, 32'hfff0_00ff, 1'b0, 5'd3);
    add_row("xor", enc_r(7'h00, 3'b100), 32'hffff_0000, 32'h0f0f_0f0f, 32'hf0f0_0f0f, 1'b0, 5'd3);
    add_row("sll", enc_r(7'h00, 3'b001), 32'd3, 32'h24, 32'h30, 1'b0, 5'd3);
    add_row("srl", enc_r(7'h00, 3'b101), 32'h8000_0000, 32'd4, 32'h0800_0000, 1'b0, 5'd3);
    add_row("sra", enc_r(7'h20, 3'b101), 32'h8000_0000, 32'd4, 32'hf800_0000, 1'b0, 5'd3);
    add_row("slt", enc_r(7'h00, 3'b010), 32'h8000_0000, 32'd1, 32'd1, 1'b0, 5'd3);
    add_row("sltu", enc_r(7'h00, 3'b011), 32'h8000_0000, 32'd1, 32'd0, 1'b0, 5'd3);
    add_row("slt", enc_r(7'h00, 3'b010), 32'd1, 32'h8000_0000, 32'd0, 1'b0, 5'd3);
    add_row("sltu", enc_r(7'h00, 3'b011), 32'd1, 32'h8000_0000, 32'd1, 1'b0, 5'd3);
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      f3 = r[2:0];
      alt = ((f3 == 3'b000) || (f3 == 3'b101)) && r[3];
      a = $random(seed);
      b = $random(seed);
      add_row("random", enc_r(alt ? 7'h20 : 7'h00, f3), a, b, reference_op(f3, alt, a, b),
              1'b0, 5'd3);
    end
    // Negative 12-bit immediates sign-extend
    add_row("addi", imm_op(3'b000, 12'hffb), 32'd3, 32'd0, 32'hffff_fffe, 1'b0, 5'd3);
    add_row("xori", imm_op(3'b100, 12'hfff), 32'h1234_5678, 32'd0, 32'hedcb_a987, 1'b0, 5'd3);
    add_row("slti", imm_op(3'b010, 12'hfff), 32'hffff_fffe, 32'd0, 32'd1, 1'b0, 5'd3);
    add_row("sltiu", imm_op(3'b011, 12'hfff), 32'd5, 32'd0, 32'd1, 1'b0, 5'd3);
    add_row("andi", imm_op(3'b111, 12'hff0), 32'h1234_567f, 32'd0, 32'h1234_5670, 1'b0, 5'd3);
    add_row("srai", imm_op(3'b101, 12'h408), 32'h8000_1000, 32'd0, 32'hff80_0010, 1'b0, 5'd3);
    add_row("lui", enc_u(riscv_pkg::OP_LUI, 20'habcde), 32'd1, 32'd2, 32'habcd_e000, 1'b0, 5'd3);
    add_row("auipc", enc_u(riscv_pkg::OP_AUIPC, 20'h12345), 32'd0, 32'd0, 32'h1234_5008,
            1'b0, 5'd3);
    // Taken branches skip the addi and store 0
    add_row("beq", enc_b(3'b000, 13'd8), 32'd7, 32'd7, 32'd0, 1'b1, 5'd3);
    add_row("beq", enc_b(3'b000, 13'd8), 32'd7, 32'd8, 32'd1, 1'b1, 5'd3);
    add_row("bne", enc_b(3'b001, 13'd8), 32'd7, 32'd8, 32'd0, 1'b1, 5'd3);
    add_row("bne", enc_b(3'b001, 13'd8), 32'd7, 32'd7, 32'd1, 1'b1, 5'd3);
    add_row("blt", enc_b(3'b100, 13'd8), 32'hffff_ffff, 32'd1, 32'd0, 1'b1, 5'd3);
    add_row("blt", enc_b(3'b100, 13'd8), 32'd1, 32'hffff_ffff, 32'd1, 1'b1, 5'd3);
    add_row("bge", enc_b(3'b101, 13'd8), 32'd1, 32'hffff_ffff, 32'd0, 1'b1, 5'd3);
    add_row("bge", enc_b(3'b101, 13'd8), 32'h8000_0000, 32'd0, 32'd1, 1'b1, 5'd3);
    add_row("bltu", enc_b(3'b110, 13'd8), 32'd1, 32'hffff_ffff, 32'd0, 1'b1, 5'd3);
    add_row("bltu", enc_b(3'b110, 13'd8), 32'hffff_ffff, 32'd1, 32'd1, 1'b1, 5'd3);
    add_row("bgeu", enc_b(3'b111, 13'd8), 32'hffff_ffff, 32'd1, 32'd0, 1'b1, 5'd3);
    add_row("bgeu", enc_b(3'b111, 13'd8), 32'd0, 32'd1, 32'd1, 1'b1, 5'd3);
    // Jump at 0x8 links 0xc and lands on the store at 0x10
    add_row("jal", enc_j(21'd8), 32'd0, 32'd0, 32'h0000_000c, 1'b1, 5'd3);
    // JALR sum is 0x11 and lands on 0x10 once bit 0 is cleared
    add_row("jalr", enc_i(riscv_pkg::OP_JALR, 3'b000, 5'd3, 5'd1, 12'd3), 32'd14, 32'd0,
            32'h0000_000c, 1'b1, 5'd3);
    // Write to x0 is dropped
    add_row("sw x0", enc_i(riscv_pkg::OP_IMM, 3'b000, 5'd0, 5'd1, 12'd5), 32'd9, 32'd0,
            32'd0, 1'b0, 5'd0);
  endtask

  task automatic build_image(input int r);
    int slot;
    // Unused words hold their own address as an illegal opcode
    for (int i = 0; i < MEM_WORDS; i++) begin
      image[i] = i * 4;
    end
    image[0] = enc_i(riscv_pkg::OP_LOAD, 3'b010, 5'd1, 5'd0, 12'h200);
    image[1] = enc_i(riscv_pkg::OP_LOAD, 3'b010, 5'd2, 5'd0, 12'h204);
    image[2] = rows[r].instr;
    slot = 3;
    if (rows[r].skip_slot) begin
      image[3] = enc_i(riscv_pkg::OP_IMM, 3'b000, 5'd3, 5'd0, 12'd1);
      slot = 4;
    end
    image[slot] = enc_s(rows[r].store_reg, STORE_ADDR[11:0]);
    image[slot + 1] = EBREAK;
    image[DATA_WORD] = rows[r].a;
    image[DATA_WORD + 1] = rows[r].b;
  endtask

  task automatic check_store(input logic [DATA_SIZE-1:0] got_addr,
                             input logic [DATA_SIZE-1:0] got_data,
                             input logic [DATA_SIZE-1:0] exp_data, input string what);
    if (got_addr !== STORE_ADDR) begin
      $display("mismatch at %0t: %s store address %h, expected %h", $time, what, got_addr,
               STORE_ADDR);
      errors++;
    end
    if (got_data !== exp_data) begin
      $display("mismatch at %0t: %s store data %h, expected %h", $time, what, got_data,
               exp_data);
      errors++;
    end
  endtask

  task automatic check_halt(input logic got, input string what);
    if (got !== 1'b1) begin
      $display("mismatch at %0t: %s halted is %b, expected 1", $time, what, got);
      errors++;
    end
  endtask

  task automatic run_row(input int r);
    int errors_before;
    errors_before = errors;
    @(posedge clock);
    reset <= 1'b1;
    build_image(r);
    load_image <= 1'b1;
    @(posedge clock);
    load_image <= 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    while (!halted) begin
      @(negedge clock);
    end
    // Halt must hold with no further store
    repeat (2) @(negedge clock);
    check_halt(halted, rows[r].name);
    if (store_count != 1) begin
      $display("mismatch at %0t: %s saw %0d store strobes, expected 1", $time, rows[r].name,
               store_count);
      errors++;
    end
    check_store(store_addr, store_data, rows[r].expected, rows[r].name);
    if (errors == errors_before) begin
      $display("row %0d %s: ok", r, rows[r].name);
    end else begin
      $display("row %0d %s: failed", r, rows[r].name);
      failed_rows++;
    end
  endtask

  initial begin
    reset = 1'b1;
    load_image = 1'b0;
    build_table();
    cycle_limit = rows.size() * (RESET_CYCLES + 40) + 100;
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end
    $display("%0d rows, %0d passed, %0d failed, %0d errors", rows.size(),
             rows.size() - failed_rows, failed_rows, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- flist.f
verilog/riscv_pkg.sv
verilog/immediate_extender.sv
verilog/register_file.sv
verilog/alu.sv
verilog/dataflow.sv
verilog/control_unit.sv
verilog/riscv_core.sv
dv/riscv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the riscv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module riscv_core_tb \
  -f flist.f -o riscv_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/riscv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
exit 0

//--- verilog/alu.sv
module alu #(
  parameter int DATA_SIZE = 32
) (
  input  logic [DATA_SIZE-1:0] a,
  input  logic [DATA_SIZE-1:0] b,
  input  logic [3:0]           alu_op,
  input  logic                 sub,
  input  logic                 arithmetic,
  output logic [DATA_SIZE-1:0] y,
  output logic                 zero,
  output logic                 negative,
  output logic                 carry_out,
  output logic                 overflow
);

  localparam int SHIFT_BITS = $clog2(DATA_SIZE);

  logic [DATA_SIZE-1:0]  b_operand;
  logic [DATA_SIZE-1:0]  sum;
  logic [SHIFT_BITS-1:0] shamt;

  // One adder, subtract is a plus inverted b plus one
  assign b_operand = sub ? ~b : b;
  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_operand} + {{DATA_SIZE{1'b0}}, sub};

  assign zero = (sum == '0);
  assign negative = sum[DATA_SIZE-1];
  assign overflow = (a[DATA_SIZE-1] == b_operand[DATA_SIZE-1]) &&
                    (sum[DATA_SIZE-1] != a[DATA_SIZE-1]);
  assign shamt = b[SHIFT_BITS-1:0];

  always_comb begin
    case (alu_op)
      riscv_pkg::ALU_SLL:  y = a << shamt;
      // Compares rely on sub being set
      riscv_pkg::ALU_SLT:  y = {{(DATA_SIZE-1){1'b0}}, negative ^ overflow};
      riscv_pkg::ALU_SLTU: y = {{(DATA_SIZE-1){1'b0}}, ~carry_out};
      riscv_pkg::ALU_XOR:  y = a ^ b;
      riscv_pkg::ALU_SRL: begin
        if (arithmetic) begin
          y = $signed(a) >>> shamt;
        end else begin
          y = a >> shamt;
        end
      end
      riscv_pkg::ALU_OR:   y = a | b;
      riscv_pkg::ALU_AND:  y = a & b;
      default:             y = sum;
    endcase
  end

endmodule

//--- verilog/control_unit.sv
module control_unit (
  input  logic       clock,
  input  logic       reset,
  input  logic [6:0] opcode,
  input  logic [2:0] funct3,
  input  logic [6:0] funct7,
  input  logic       zero,
  input  logic       negative,
  input  logic       carry_out,
  input  logic       overflow,
  output logic       ir_en,
  output logic       pc_en,
  output logic       alua_src,
  output logic       alub_src,
  output logic [3:0] alu_op,
  output logic       sub,
  output logic       arithmetic,
  output logic       alupc_src,
  output logic       pc_src,
  output logic [1:0] wr_reg_src,
  output logic       wr_reg_en,
  output logic       mem_addr_src,
  output logic       mem_wr_en,
  output logic       halted
);

  localparam logic [2:0] S_FETCH     = 3'd0;
  localparam logic [2:0] S_DECODE    = 3'd1;
  localparam logic [2:0] S_EXECUTE   = 3'd2;
  localparam logic [2:0] S_MEMORY    = 3'd3;
  localparam logic [2:0] S_WRITEBACK = 3'd4;
  localparam logic [2:0] S_HALT      = 3'd5;

  logic [2:0] state;
  logic [2:0] next_state;
  logic       is_load;
  logic       is_store;
  logic       is_branch;
  logic       is_op;
  logic       is_imm;
  logic       is_jump;
  logic       legal;
  logic       condition;
  logic       is_compare;

  assign is_load = (opcode == riscv_pkg::OP_LOAD);
  assign is_store = (opcode == riscv_pkg::OP_STORE);
  assign is_branch = (opcode == riscv_pkg::OP_BRANCH);
  assign is_op = (opcode == riscv_pkg::OP_REG);
  assign is_imm = (opcode == riscv_pkg::OP_IMM);
  assign is_jump = (opcode == riscv_pkg::OP_JAL) || (opcode == riscv_pkg::OP_JALR);
  // SYSTEM is left out, so EBREAK halts like any unknown opcode
  assign legal = is_load || is_store || is_branch || is_op || is_imm || is_jump ||
                 (opcode == riscv_pkg::OP_LUI) || (opcode == riscv_pkg::OP_AUIPC);

  // funct3[0] inverts bne, bge and bgeu
  always_comb begin
    case (funct3[2:1])
      2'b00:   condition = zero;
      2'b10:   condition = negative ^ overflow;
      2'b11:   condition = ~carry_out;
      default: condition = 1'b0;
    endcase
  end

  assign is_compare = ({1'b0, funct3} == riscv_pkg::ALU_SLT) ||
                      ({1'b0, funct3} == riscv_pkg::ALU_SLTU);

  // Datapath setup follows the opcode, enables follow the state
  assign alua_src = (opcode == riscv_pkg::OP_AUIPC);
  assign alub_src = !(is_op || is_branch);
  assign alu_op = (is_op || is_imm) ? {1'b0, funct3} : riscv_pkg::ALU_ADD;
  assign sub = is_branch || ((is_op || is_imm) && is_compare) ||
               (is_op && (funct3 == 3'b000) && funct7[5]);
  assign arithmetic = (is_op || is_imm) && funct7[5];
  assign alupc_src = (opcode == riscv_pkg::OP_JALR);
  assign pc_src = is_jump || (is_branch && (condition ^ funct3[0]));
  assign wr_reg_src = is_load ? riscv_pkg::WB_LOAD :
                      is_jump ? riscv_pkg::WB_PC4 :
                      (opcode == riscv_pkg::OP_LUI) ? riscv_pkg::WB_IMM : riscv_pkg::WB_ALU;

  assign ir_en = (state == S_FETCH);
  assign pc_en = ((state == S_EXECUTE) && is_branch) ||
                 ((state == S_MEMORY) && is_store) || (state == S_WRITEBACK);
  assign wr_reg_en = (state == S_WRITEBACK);
  assign mem_wr_en = (state == S_MEMORY) && is_store;
  // Loads keep the data address on the bus through write-back
  assign mem_addr_src = (state == S_MEMORY) || ((state == S_WRITEBACK) && is_load);
  assign halted = (state == S_HALT);

  always_comb begin
    case (state)
      S_FETCH:     next_state = S_DECODE;
      S_DECODE:    next_state = legal ? S_EXECUTE : S_HALT;
      S_EXECUTE: begin
        if (is_branch) begin
          next_state = S_FETCH;
        end else if (is_load || is_store) begin
          next_state = S_MEMORY;
        end else begin
          next_state = S_WRITEBACK;
        end
      end
      S_MEMORY:    next_state = is_store ? S_FETCH : S_WRITEBACK;
      S_HALT:      next_state = S_HALT;
      default:     next_state = S_FETCH;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_FETCH;
    end else begin
      state <= next_state;
    end
  end

  a_no_dual_write: assert property (@(posedge clock) disable iff (reset)
    !(mem_wr_en && wr_reg_en));
  a_halt_sticky: assert property (@(posedge clock) disable iff (reset)
    halted |=> halted);

endmodule

//--- verilog/dataflow.sv
module dataflow #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [DATA_SIZE-1:0] rd_data,
  output logic [DATA_SIZE-1:0] mem_addr,
  output logic [DATA_SIZE-1:0] wr_data,
  input  logic                 ir_en,
  input  logic                 pc_en,
  input  logic                 alua_src,
  input  logic                 alub_src,
  input  logic [3:0]           alu_op,
  input  logic                 sub,
  input  logic                 arithmetic,
  input  logic                 alupc_src,
  input  logic                 pc_src,
  input  logic [1:0]           wr_reg_src,
  input  logic                 wr_reg_en,
  input  logic                 mem_addr_src,
  output logic [6:0]           opcode,
  output logic [2:0]           funct3,
  output logic [6:0]           funct7,
  output logic                 zero,
  output logic                 negative,
  output logic                 carry_out,
  output logic                 overflow
);

  riscv_pkg::instr_u    ir;
  logic [DATA_SIZE-1:0] pc;
  logic [DATA_SIZE-1:0] pc_plus_4;
  logic [DATA_SIZE-1:0] target_sum;
  logic [DATA_SIZE-1:0] rs1;
  logic [DATA_SIZE-1:0] rs2;
  logic [DATA_SIZE-1:0] rd;
  logic [DATA_SIZE-1:0] immediate;
  logic [DATA_SIZE-1:0] alu_y;
  logic [4:0]           rs1_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (pc_en) begin
      // JALR target has bit 0 cleared
      pc <= pc_src ? {target_sum[DATA_SIZE-1:1], 1'b0} : pc_plus_4;
    end
  end

  always_ff @(posedge clock) begin
    if (ir_en) begin
      ir <= rd_data[31:0];
    end
  end

  assign pc_plus_4 = pc + DATA_SIZE'(4);
  assign target_sum = (alupc_src ? rs1 : pc) + immediate;

  // LUI carries immediate bits in the rs1 field
  assign rs1_addr = (ir.r_fmt.opcode == riscv_pkg::OP_LUI) ? 5'd0 : ir.r_fmt.rs1;

  always_comb begin
    case (wr_reg_src)
      riscv_pkg::WB_LOAD: rd = rd_data;
      riscv_pkg::WB_PC4:  rd = pc_plus_4;
      riscv_pkg::WB_IMM:  rd = immediate;
      default:            rd = alu_y;
    endcase
  end

  register_file #(
    .DATA_SIZE(DATA_SIZE)
  ) i_register_file (
    .clock        (clock),
    .reset        (reset),
    .write_enable (wr_reg_en),
    .read_address1(rs1_addr),
    .read_address2(ir.r_fmt.rs2),
    .write_address(ir.r_fmt.rd),
    .write_data   (rd),
    .read_data1   (rs1),
    .read_data2   (rs2)
  );

  immediate_extender #(
    .DATA_SIZE(DATA_SIZE)
  ) i_immediate_extender (
    .instruction(ir),
    .immediate  (immediate)
  );

  alu #(
    .DATA_SIZE(DATA_SIZE)
  ) i_alu (
    .a         (alua_src ? pc : rs1),
    .b         (alub_src ? immediate : rs2),
    .alu_op    (alu_op),
    .sub       (sub),
    .arithmetic(arithmetic),
    .y         (alu_y),
    .zero      (zero),
    .negative  (negative),
    .carry_out (carry_out),
    .overflow  (overflow)
  );

  assign mem_addr = mem_addr_src ? alu_y : pc;
  assign wr_data = rs2;
  assign opcode = ir.r_fmt.opcode;
  assign funct3 = ir.r_fmt.funct3;
  assign funct7 = ir.r_fmt.funct7;

  // Only word accesses exist, data addresses must be aligned
  a_word_aligned: assert property (@(posedge clock) disable iff (reset)
    mem_addr_src |-> (mem_addr[1:0] == 2'b00));

endmodule

//--- verilog/immediate_extender.sv
module immediate_extender #(
  parameter int DATA_SIZE = 32
) (
  input  riscv_pkg::instr_u    instruction,
  output logic [DATA_SIZE-1:0] immediate
);

  logic [31:0] imm32;

  always_comb begin
    case (instruction.r_fmt.opcode)
      riscv_pkg::OP_STORE: begin
        imm32 = {{20{instruction.s_fmt.imm_hi[6]}}, instruction.s_fmt.imm_hi,
                 instruction.s_fmt.imm_lo};
      end
      // Branch offsets are in halfwords
      riscv_pkg::OP_BRANCH: begin
        imm32 = {{20{instruction.b_fmt.imm_12}}, instruction.b_fmt.imm_11,
                 instruction.b_fmt.imm_10_5, instruction.b_fmt.imm_4_1, 1'b0};
      end
      riscv_pkg::OP_LUI,
      riscv_pkg::OP_AUIPC: begin
        imm32 = {instruction.u_fmt.imm, 12'b0};
      end
      riscv_pkg::OP_JAL: begin
        imm32 = {{12{instruction.j_fmt.imm_20}}, instruction.j_fmt.imm_19_12,
                 instruction.j_fmt.imm_11, instruction.j_fmt.imm_10_1, 1'b0};
      end
      // I format: OP-IMM, loads and JALR
      default: begin
        imm32 = {{20{instruction.i_fmt.imm[11]}}, instruction.i_fmt.imm};
      end
    endcase
  end

  // Bit 31 holds the sign for every format
  assign immediate = DATA_SIZE'($signed(imm32));

endmodule

//--- verilog/register_file.sv
module register_file #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 write_enable,
  input  logic [4:0]           read_address1,
  input  logic [4:0]           read_address2,
  input  logic [4:0]           write_address,
  input  logic [DATA_SIZE-1:0] write_data,
  output logic [DATA_SIZE-1:0] read_data1,
  output logic [DATA_SIZE-1:0] read_data2
);

  logic [DATA_SIZE-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_address != 5'd0)) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = regs[read_address1];
  assign read_data2 = regs[read_address2];

  // x0 keeps its reset value through every write
  a_x0_zero: assert property (@(posedge clock) disable iff (reset)
    (read_address1 == 5'd0) |-> (read_data1 == '0));

endmodule

//--- verilog/riscv_core.sv
module riscv_core #(
  parameter int DATA_SIZE = 32
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [DATA_SIZE-1:0] rd_data,
  output logic [DATA_SIZE-1:0] mem_addr,
  output logic [DATA_SIZE-1:0] wr_data,
  output logic                 mem_wr_en,
  output logic                 halted
);

  // Control unit to dataflow
  logic       ir_en;
  logic       pc_en;
  logic       alua_src;
  logic       alub_src;
  logic [3:0] alu_op;
  logic       sub;
  logic       arithmetic;
  logic       alupc_src;
  logic       pc_src;
  logic [1:0] wr_reg_src;
  logic       wr_reg_en;
  logic       mem_addr_src;

  // Decode fields and ALU flags back to the control unit
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       zero;
  logic       negative;
  logic       carry_out;
  logic       overflow;

  // Both blocks connect by matching port names
  control_unit i_control_unit (
    .*
  );

  dataflow #(
    .DATA_SIZE(DATA_SIZE)
  ) i_dataflow (
    .*
  );

endmodule

//--- verilog/riscv_pkg.sv
package riscv_pkg;

  // RV32I base opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ALU operations, low three bits are the funct3 of OP and OP-IMM
  localparam logic [3:0] ALU_ADD  = 4'b0000;
  localparam logic [3:0] ALU_SLL  = 4'b0001;
  localparam logic [3:0] ALU_SLT  = 4'b0010;
  localparam logic [3:0] ALU_SLTU = 4'b0011;
  localparam logic [3:0] ALU_XOR  = 4'b0100;
  localparam logic [3:0] ALU_SRL  = 4'b0101;
  localparam logic [3:0] ALU_OR   = 4'b0110;
  localparam logic [3:0] ALU_AND  = 4'b0111;

  // Register write-back sources
  localparam logic [1:0] WB_ALU  = 2'b00;
  localparam logic [1:0] WB_LOAD = 2'b01;
  localparam logic [1:0] WB_PC4  = 2'b10;
  localparam logic [1:0] WB_IMM  = 2'b11;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } instr_u;

endpackage
